// File: logic/cache_geom_pkg.sv
package cache_geom_pkg;

  // cache shape
  localparam int NUM_WAYS   = 4;
  localparam int NUM_SETS   = 32;
  localparam int LINE_WORDS = 16;
  localparam int WORD_BYTES = 4;

  // address field positions
  localparam int WORD_LSB  = 2;   // word select starts here
  localparam int INDEX_LSB = 6;   // set index starts here
  localparam int TAG_LSB   = 11;
  localparam int IO_LSB    = 28;  // top nibble picks the io region

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [WORD_BYTES-1:0] byte_mask_t;

  typedef logic [4:0] index_t;      // addr[10:6]
  typedef logic [3:0] word_sel_t;   // addr[5:2]
  typedef logic [8:0] word_addr_t;  // {index, word_sel}
  typedef logic [20:0] tag_t;       // addr[31:11]
  typedef logic [1:0] way_t;

endpackage

// File: logic/cache_bus_pkg.sv
package cache_bus_pkg;

  // master request, 70 bits
  typedef struct packed {
    cache_geom_pkg::addr_t      address;
    cache_geom_pkg::byte_mask_t byte_en;
    logic                       read;
    logic                       write;
    cache_geom_pkg::word_t      wdata;
  } rw_req_t;

  // line install from the engine, 28 bits
  typedef struct packed {
    cache_geom_pkg::index_t index;
    cache_geom_pkg::way_t   way;
    cache_geom_pkg::tag_t   tag;
  } fill_t;

  typedef enum logic [1:0] {
    cmd_nop,
    cmd_refill,
    cmd_io
  } cmd_kind_t;

  // command to the engine, carries the faulting request
  typedef struct packed {
    cmd_kind_t kind;
    rw_req_t   req;
  } miss_cmd_t;

  typedef enum logic {
    st_idle,
    st_wait_done
  } ctrl_state_t;

endpackage

// File: logic/tag_array.sv
`timescale 1ns/1ps

module tag_array (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   lookup_en,
  input  cache_geom_pkg::index_t lookup_index,
  input  cache_geom_pkg::tag_t   lookup_tag,
  input  logic                   fill_en,
  input  cache_bus_pkg::fill_t   fill,
  output logic                   hit,
  output cache_geom_pkg::way_t   hit_way
);

  cache_geom_pkg::tag_t tags [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
  logic [cache_geom_pkg::NUM_WAYS-1:0] valid [cache_geom_pkg::NUM_SETS];  // one bit per way

  cache_geom_pkg::tag_t rd_tags [cache_geom_pkg::NUM_WAYS];
  logic [cache_geom_pkg::NUM_WAYS-1:0] rd_valid;

  // tag ram, written by the fill port
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tags[fill.way][fill.index] <= fill.tag;
    end
    if (lookup_en) begin
      for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
        rd_tags[w] <= tags[w][lookup_index];  // all ways of the set
      end
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
        valid[s] <= '0;
      end
      rd_valid <= '0;
    end else begin
      if (fill_en) begin
        valid[fill.index][fill.way] <= 1'b1;
      end
      if (lookup_en) begin
        rd_valid <= valid[lookup_index];
      end
    end
  end

  // compare in the lookup cycle against the registered request tag
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
      if (rd_valid[w] && (rd_tags[w] == lookup_tag)) begin
        hit     = 1'b1;
        hit_way = cache_geom_pkg::way_t'(w);
      end
    end
  end

endmodule

// File: logic/line_store.sv
`timescale 1ns/1ps

module line_store (
  input  logic                       clk,
  input  logic                       rd_en,
  input  cache_geom_pkg::word_addr_t rd_addr,
  input  cache_geom_pkg::way_t       sel_way,
  input  logic                       wr_en,
  input  cache_geom_pkg::word_addr_t wr_addr,
  input  cache_geom_pkg::way_t       wr_way,
  input  cache_geom_pkg::word_t      wr_data,
  input  cache_geom_pkg::byte_mask_t wr_mask,
  input  logic                       fill_en,
  input  cache_bus_pkg::fill_t       fill,
  output cache_geom_pkg::word_t      rd_data,
  output cache_geom_pkg::byte_mask_t rd_readable
);

  localparam int DEPTH = cache_geom_pkg::NUM_SETS * cache_geom_pkg::LINE_WORDS;

  cache_geom_pkg::word_t      mem      [cache_geom_pkg::NUM_WAYS][DEPTH];
  cache_geom_pkg::byte_mask_t readable [cache_geom_pkg::NUM_WAYS][DEPTH];

  // read registers, one per way, way picked after the tag compare
  cache_geom_pkg::word_t      rd_words [cache_geom_pkg::NUM_WAYS];
  cache_geom_pkg::byte_mask_t rd_masks [cache_geom_pkg::NUM_WAYS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < cache_geom_pkg::WORD_BYTES; b++) begin
        if (wr_mask[b]) begin
          mem[wr_way][wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
    if (rd_en) begin
      for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
        rd_words[w] <= mem[w][rd_addr];  // old word on a same-edge write
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      // a new tag makes the whole line unreadable
      for (int k = 0; k < cache_geom_pkg::LINE_WORDS; k++) begin
        readable[fill.way][{fill.index, cache_geom_pkg::word_sel_t'(k)}] <= '0;
      end
    end else if (wr_en) begin
      readable[wr_way][wr_addr] <= readable[wr_way][wr_addr] | wr_mask;
    end
    if (rd_en) begin
      for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
        rd_masks[w] <= readable[w][rd_addr];
      end
    end
  end

  assign rd_data     = rd_words[sel_way];
  assign rd_readable = rd_masks[sel_way];

endmodule

// File: logic/rw_ctrl.sv
`timescale 1ns/1ps

module rw_ctrl #(
  parameter logic [3:0] IO_REGION = 4'hF
) (
  input  logic                       clk,
  input  logic                       rest,
  input  cache_bus_pkg::rw_req_t     req,
  input  logic                       hit,
  input  cache_geom_pkg::way_t       hit_way,
  input  cache_geom_pkg::word_t      rd_data,
  input  cache_geom_pkg::byte_mask_t rd_readable,
  input  logic                       cmd_done,
  input  cache_geom_pkg::word_t      rsp_data,
  output logic                       wait_request,
  output cache_geom_pkg::word_t      read_data,
  output logic                       read_valid,
  output cache_bus_pkg::miss_cmd_t   cmd,
  output logic                       lookup_en,
  output cache_geom_pkg::tag_t       lookup_tag,
  output cache_geom_pkg::word_addr_t rd_addr,
  output logic                       wr_en,
  output cache_geom_pkg::word_addr_t wr_addr,
  output cache_geom_pkg::way_t       wr_way,
  output cache_geom_pkg::word_t      wr_data,
  output cache_geom_pkg::byte_mask_t wr_mask
);

  cache_bus_pkg::rw_req_t     cur;   // request in its lookup cycle
  cache_bus_pkg::rw_req_t     prev;  // the one taken just before cur
  cache_bus_pkg::ctrl_state_t state;
  cache_bus_pkg::cmd_kind_t   cmd_kind;
  cache_bus_pkg::rw_req_t     cmd_req;

  logic                       cur_valid;
  logic                       is_io;
  logic                       fwd;
  logic                       not_readable;
  logic                       fault;
  cache_geom_pkg::byte_mask_t fwd_mask;
  cache_geom_pkg::byte_mask_t readable_mask;
  cache_geom_pkg::word_t      merged;

  // ram and tag reads are launched with the incoming address
  assign rd_addr    = req.address[cache_geom_pkg::TAG_LSB-1:cache_geom_pkg::WORD_LSB];
  assign lookup_en  = !wait_request;
  assign lookup_tag = cur.address[31:cache_geom_pkg::TAG_LSB];

  assign cur_valid = cur.read | cur.write;
  assign is_io     = (cur.address[31:cache_geom_pkg::IO_LSB] == IO_REGION);

  // prev write lands at the same edge as cur's ram read, so the ram misses it
  assign fwd = prev.write &&
               (prev.address[31:cache_geom_pkg::WORD_LSB] ==
                cur.address[31:cache_geom_pkg::WORD_LSB]);
  assign fwd_mask      = fwd ? prev.byte_en : '0;
  assign readable_mask = rd_readable | fwd_mask;
  assign not_readable  = cur.read && ((cur.byte_en & ~readable_mask) != '0);

  assign fault = cur_valid && (is_io || !hit || not_readable);

  always_comb begin
    merged = rd_data;
    for (int b = 0; b < cache_geom_pkg::WORD_BYTES; b++) begin
      if (fwd_mask[b]) begin
        merged[8*b +: 8] = prev.wdata[8*b +: 8];
      end
    end
  end

  // stall while a command is out, and in the cycle a fault is found
  assign wait_request = (state == cache_bus_pkg::st_wait_done) || fault;

  assign read_valid = (state == cache_bus_pkg::st_wait_done) ? (cmd_done && cur.read)
                                                              : (cur.read && !fault);
  assign read_data  = (state == cache_bus_pkg::st_wait_done) ? rsp_data : merged;

  // write hit commits at the end of the lookup cycle
  assign wr_en   = (state == cache_bus_pkg::st_idle) && cur.write && !fault;
  assign wr_addr = cur.address[cache_geom_pkg::TAG_LSB-1:cache_geom_pkg::WORD_LSB];
  assign wr_way  = hit_way;
  assign wr_data = cur.wdata;
  assign wr_mask = cur.byte_en;

  // request pipe, shifts whenever the front end is not stalled
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      cur  <= '0;
      prev <= '0;
    end else if (!wait_request) begin
      cur  <= req;  // strobes low when nothing is offered
      prev <= cur;
    end else if ((state == cache_bus_pkg::st_wait_done) && cmd_done) begin
      cur.read  <= 1'b0;  // engine finished it
      cur.write <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state    <= cache_bus_pkg::st_idle;
      cmd_kind <= cache_bus_pkg::cmd_nop;
    end else begin
      case (state)
        cache_bus_pkg::st_idle: begin
          if (fault) begin
            state    <= cache_bus_pkg::st_wait_done;
            cmd_kind <= is_io ? cache_bus_pkg::cmd_io : cache_bus_pkg::cmd_refill;
          end
        end
        cache_bus_pkg::st_wait_done: begin
          if (cmd_done) begin
            state    <= cache_bus_pkg::st_idle;
            cmd_kind <= cache_bus_pkg::cmd_nop;
          end
        end
      endcase
    end
  end

  // faulting request is handed to the engine with the command
  always_ff @(posedge clk) begin
    if ((state == cache_bus_pkg::st_idle) && fault) begin
      cmd_req <= cur;
    end
  end

  assign cmd.kind = cmd_kind;
  assign cmd.req  = cmd_req;

endmodule

// File: logic/cache_rw_top.sv
`timescale 1ns/1ps

module cache_rw_top #(
  parameter logic [3:0] IO_REGION = 4'hF  // top address nibble of the io space
) (
  input  logic                     clk,
  input  logic                     rest,
  input  cache_bus_pkg::rw_req_t   req,
  output logic                     wait_request,
  output cache_geom_pkg::word_t    read_data,
  output logic                     read_valid,
  output cache_bus_pkg::miss_cmd_t cmd,
  input  logic                     cmd_done,
  input  cache_geom_pkg::word_t    rsp_data,
  input  logic                     fill_en,
  input  cache_bus_pkg::fill_t     fill
);

  logic                       lookup_en;
  cache_geom_pkg::tag_t       lookup_tag;
  logic                       hit;
  cache_geom_pkg::way_t       hit_way;
  cache_geom_pkg::word_addr_t rd_addr;
  cache_geom_pkg::word_t      rd_data;
  cache_geom_pkg::byte_mask_t rd_readable;
  logic                       wr_en;
  cache_geom_pkg::word_addr_t wr_addr;
  cache_geom_pkg::way_t       wr_way;
  cache_geom_pkg::word_t      wr_data;
  cache_geom_pkg::byte_mask_t wr_mask;

  tag_array u_tag_array (
    .clk          (clk),
    .rest         (rest),
    .lookup_en    (lookup_en),
    // set index is the upper part of the word address
    .lookup_index (rd_addr[cache_geom_pkg::TAG_LSB-cache_geom_pkg::WORD_LSB-1:
                           cache_geom_pkg::INDEX_LSB-cache_geom_pkg::WORD_LSB]),
    .lookup_tag   (lookup_tag),
    .fill_en      (fill_en),
    .fill         (fill),
    .hit          (hit),
    .hit_way      (hit_way)
  );

  line_store u_line_store (
    .clk         (clk),
    .rd_en       (lookup_en),
    .rd_addr     (rd_addr),
    .sel_way     (hit_way),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_way      (wr_way),
    .wr_data     (wr_data),
    .wr_mask     (wr_mask),
    .fill_en     (fill_en),
    .fill        (fill),
    .rd_data     (rd_data),
    .rd_readable (rd_readable)
  );

  rw_ctrl #(
    .IO_REGION (IO_REGION)
  ) u_rw_ctrl (
    .clk          (clk),
    .rest         (rest),
    .req          (req),
    .hit          (hit),
    .hit_way      (hit_way),
    .rd_data      (rd_data),
    .rd_readable  (rd_readable),
    .cmd_done     (cmd_done),
    .rsp_data     (rsp_data),
    .wait_request (wait_request),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .cmd          (cmd),
    .lookup_en    (lookup_en),
    .lookup_tag   (lookup_tag),
    .rd_addr      (rd_addr),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_way       (wr_way),
    .wr_data      (wr_data),
    .wr_mask      (wr_mask)
  );

endmodule

// File: bench/cache_ref.svh
`ifndef CACHE_REF_SVH
`define CACHE_REF_SVH

// what the cache should hold, updated as requests are accepted
cache_geom_pkg::word_t      ref_mem [logic [29:0]];  // written words only, by word address
cache_geom_pkg::tag_t       ref_tag [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
logic                       ref_valid [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
cache_geom_pkg::byte_mask_t ref_rd [cache_geom_pkg::NUM_WAYS][512];  // readable bytes
logic [15:0]                lfsr_state = 16'd46;

function automatic void ref_reset();
  for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
    for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
      ref_valid[w][s] = 1'b0;
    end
  end
endfunction

function automatic cache_geom_pkg::word_t byte_bits(cache_geom_pkg::byte_mask_t m);
  return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

// memory never written reads back a pattern of its full address
function automatic cache_geom_pkg::word_t ref_read(cache_geom_pkg::addr_t a);
  if (ref_mem.exists(a[31:2])) begin
    return ref_mem[a[31:2]];
  end
  return {a[31:2], 2'b11} ^ 32'h6d2b_79f5;
endfunction

function automatic void ref_fill(cache_bus_pkg::fill_t f);
  ref_tag[f.way][f.index]   = f.tag;
  ref_valid[f.way][f.index] = 1'b1;
  for (int k = 0; k < 16; k++) begin
    ref_rd[f.way][{f.index, 4'(k)}] = '0;  // new line starts unreadable
  end
endfunction

// expected command for a request, applies a write as it goes
function automatic cache_bus_pkg::cmd_kind_t ref_accept(cache_bus_pkg::rw_req_t r);
  logic                       found;
  cache_geom_pkg::way_t       w;
  cache_geom_pkg::word_addr_t wa;
  cache_geom_pkg::word_t      word;
  cache_bus_pkg::cmd_kind_t   kind;
  found = 1'b0;
  w     = '0;
  wa    = r.address[10:2];
  for (int i = 0; i < cache_geom_pkg::NUM_WAYS; i++) begin
    if (ref_valid[i][wa[8:4]] && (ref_tag[i][wa[8:4]] == r.address[31:11])) begin
      found = 1'b1;
      w     = 2'(i);
    end
  end
  if (r.address[31:28] == IO_REGION) begin
    kind = cache_bus_pkg::cmd_io;
  end else if (!found) begin
    kind = cache_bus_pkg::cmd_refill;
  end else if (r.read && ((r.byte_en & ~ref_rd[w][wa]) != '0)) begin
    kind = cache_bus_pkg::cmd_refill;  // some enabled byte never written
  end else begin
    kind = cache_bus_pkg::cmd_nop;
  end
  if (r.write) begin
    word = ref_read(r.address);
    word = (word & ~byte_bits(r.byte_en)) | (r.wdata & byte_bits(r.byte_en));
    ref_mem[r.address[31:2]] = word;
    if (kind == cache_bus_pkg::cmd_nop) begin
      ref_rd[w][wa] = ref_rd[w][wa] | r.byte_en;
    end
  end
  return kind;
endfunction

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);  // one step per bit
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

`endif

// File: bench/cache_rw_tb.sv
`timescale 1ns/1ps

module cache_rw_tb;

  localparam logic [3:0] IO_REGION = 4'hF;
  localparam int N_DIRECTED = 12;
  localparam int N_RANDOM   = 200;
  localparam int MAX_CYCLES = 40 * (N_DIRECTED + N_RANDOM);

  localparam cache_geom_pkg::tag_t TAG_A  = 21'h00123;
  localparam cache_geom_pkg::tag_t TAG_B  = 21'h0abcd;  // never installed
  localparam cache_geom_pkg::tag_t TAG_C  = 21'h00777;
  localparam cache_geom_pkg::tag_t TAG_D  = 21'h0beef;
  localparam cache_geom_pkg::tag_t TAG_IO = {IO_REGION, 17'h00042};

  logic                     clk;
  logic                     rest;
  cache_bus_pkg::rw_req_t   req;
  logic                     wait_request;
  cache_geom_pkg::word_t    read_data;
  logic                     read_valid;
  cache_bus_pkg::miss_cmd_t cmd;
  logic                     cmd_done;
  cache_geom_pkg::word_t    rsp_data;
  logic                     fill_en;
  cache_bus_pkg::fill_t     fill;

  string test_name = "none";
  int    test_errors = 0;
  int    total_errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;

  // expectations in acceptance order
  cache_geom_pkg::word_t      exp_words [$];
  cache_geom_pkg::byte_mask_t exp_masks [$];
  logic                       exp_faults [$];  // read answered by the engine
  cache_bus_pkg::cmd_kind_t   exp_kinds [$];
  cache_bus_pkg::rw_req_t     exp_reqs [$];

  `include "cache_ref.svh"

  cache_rw_top #(
    .IO_REGION (IO_REGION)
  ) dut0 (
    .clk          (clk),
    .rest         (rest),
    .req          (req),
    .wait_request (wait_request),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .cmd          (cmd),
    .cmd_done     (cmd_done),
    .rsp_data     (rsp_data),
    .fill_en      (fill_en),
    .fill         (fill)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic cache_geom_pkg::addr_t make_addr(cache_geom_pkg::tag_t t,
      cache_geom_pkg::index_t idx, cache_geom_pkg::word_sel_t ws);
    return {t, idx, ws, 2'b00};
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s, %s: expected 0x%08h, actual 0x%08h", test_name, what,
               expected, actual);
      test_errors++;
    end
  endtask

  task automatic idle();
    req.read  = 1'b0;
    req.write = 1'b0;
  endtask

  // entered 2 ns after a rising edge and left at the same point of the lookup cycle
  task automatic issue(input logic is_write, input cache_geom_pkg::addr_t a,
                       input cache_geom_pkg::byte_mask_t be, input cache_geom_pkg::word_t d);
    cache_bus_pkg::cmd_kind_t kind;
    req.address = a;
    req.byte_en = be;
    req.read    = !is_write;
    req.write   = is_write;
    req.wdata   = d;
    @(negedge clk);
    while (wait_request) begin
      @(negedge clk);  // master holds req
    end
    kind = ref_accept(req);
    if (!is_write) begin
      exp_words.push_back(ref_read(a) & byte_bits(be));
      exp_masks.push_back(be);
      exp_faults.push_back(kind != cache_bus_pkg::cmd_nop);
    end
    if (kind != cache_bus_pkg::cmd_nop) begin
      exp_kinds.push_back(kind);
      exp_reqs.push_back(req);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic drain();
    idle();
    @(negedge clk);
    while (wait_request || (cmd.kind != cache_bus_pkg::cmd_nop) ||
           (exp_words.size() != 0) || (exp_kinds.size() != 0)) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  // fill port only with nothing in flight
  task automatic install(input cache_geom_pkg::index_t idx, input cache_geom_pkg::way_t way,
                         input cache_geom_pkg::tag_t tag);
    drain();
    fill_en    = 1'b1;
    fill.index = idx;
    fill.way   = way;
    fill.tag   = tag;
    @(posedge clk);
    #2;
    fill_en = 1'b0;
    ref_fill(fill);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    drain();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, test_errors);
    end
    total_errors += test_errors;
  endtask

  // engine answers every command after 3 cycles
  initial begin
    cmd_done = 1'b0;
    rsp_data = '0;
    forever begin
      @(negedge clk);
      if (rest && (cmd.kind != cache_bus_pkg::cmd_nop)) begin
        repeat (3) @(posedge clk);
        #2;
        cmd_done = 1'b1;
        rsp_data = ref_read(cmd.req.address);  // writes are already in ref_mem
        @(posedge clk);
        #2;
        cmd_done = 1'b0;
      end
    end
  end

  // outputs sampled mid-cycle on the falling edge
  initial begin : compare
    cache_bus_pkg::cmd_kind_t last_kind;
    cache_geom_pkg::word_t    keep;
    cache_bus_pkg::rw_req_t   fault_req;
    last_kind = cache_bus_pkg::cmd_nop;
    forever begin
      @(negedge clk);
      if (rest) begin
        if (read_valid) begin
          if (exp_words.size() == 0) begin
            check("read_valid with no read pending", 32'd0, 32'd1);
          end else begin
            keep = byte_bits(exp_masks.pop_front());
            check("read data", exp_words.pop_front(), read_data & keep);
            check("cmd_done with read_valid", 32'(exp_faults.pop_front()), 32'(cmd_done));
          end
        end
        if ((cmd.kind != cache_bus_pkg::cmd_nop) && (last_kind == cache_bus_pkg::cmd_nop)) begin
          if (exp_kinds.size() == 0) begin
            check("command where a hit was due", 32'(cache_bus_pkg::cmd_nop), 32'(cmd.kind));
          end else begin
            fault_req = exp_reqs.pop_front();
            check("command kind", 32'(exp_kinds.pop_front()), 32'(cmd.kind));
            check("command address", fault_req.address, cmd.req.address);
            check("command byte_en", 32'(fault_req.byte_en), 32'(cmd.req.byte_en));
            check("command strobes", 32'({fault_req.read, fault_req.write}),
                  32'({cmd.req.read, cmd.req.write}));
            check("command wdata", fault_req.wdata, cmd.req.wdata);
          end
        end
        last_kind = cmd.kind;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles, a request or command never finished",
             cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    cache_geom_pkg::tag_t       rnd_tag [4];
    cache_geom_pkg::index_t     rnd_idx [4];
    logic [1:0]                 pick;
    cache_geom_pkg::byte_mask_t be;
    ref_reset();
    req     = '0;
    fill_en = 1'b0;
    fill    = '0;
    rest    = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rest = 1'b1;

    start_test("reset_state");
    @(negedge clk);
    check("wait_request", 32'd0, 32'(wait_request));
    check("read_valid", 32'd0, 32'(read_valid));
    check("cmd kind", 32'(cache_bus_pkg::cmd_nop), 32'(cmd.kind));
    end_test();

    start_test("write_read_hit");
    install(5'd3, 2'd0, TAG_A);
    issue(1'b1, make_addr(TAG_A, 5'd3, 4'd5), 4'hf, 32'hcafe_0001);
    idle();
    @(posedge clk);
    #2;
    issue(1'b0, make_addr(TAG_A, 5'd3, 4'd5), 4'hf, 32'h0);
    idle();
    @(negedge clk);
    check("read_valid in the lookup cycle", 32'd1, 32'(read_valid));
    end_test();

    start_test("refill_commands");
    issue(1'b0, make_addr(TAG_A, 5'd3, 4'd9), 4'h1, 32'h0);  // byte never written in a filled line
    issue(1'b0, make_addr(TAG_B, 5'd7, 4'd2), 4'hf, 32'h0);
    issue(1'b1, make_addr(TAG_B, 5'd7, 4'd3), 4'h6, 32'h1234_5678);
    end_test();

    start_test("io_region");
    install(5'd2, 2'd1, TAG_IO);  // io even with its tag present
    issue(1'b0, make_addr(TAG_IO, 5'd2, 4'd0), 4'hf, 32'h0);
    issue(1'b1, make_addr(TAG_IO, 5'd2, 4'd1), 4'h3, 32'ha5a5_5a5a);
    issue(1'b0, make_addr({IO_REGION, 17'h10000}, 5'd9, 4'd4), 4'h8, 32'h0);
    end_test();

    start_test("write_forwarding");
    issue(1'b1, make_addr(TAG_A, 5'd3, 4'd12), 4'b0011, 32'h0bad_beef);
    issue(1'b0, make_addr(TAG_A, 5'd3, 4'd12), 4'b0011, 32'h0);
    issue(1'b1, make_addr(TAG_A, 5'd3, 4'd12), 4'b1100, 32'h7e57_0000);
    issue(1'b0, make_addr(TAG_A, 5'd3, 4'd12), 4'b1111, 32'h0);
    end_test();

    start_test("random_traffic");
    install(5'd3, 2'd2, TAG_C);
    install(5'd12, 2'd1, TAG_D);
    rnd_tag[0] = TAG_A;
    rnd_idx[0] = 5'd3;
    rnd_tag[1] = TAG_C;
    rnd_idx[1] = 5'd3;
    rnd_tag[2] = TAG_D;
    rnd_idx[2] = 5'd12;
    rnd_tag[3] = TAG_B;  // misses every time
    rnd_idx[3] = 5'd7;
    for (int i = 0; i < N_RANDOM; i++) begin
      pick = 2'(take_bits(2));
      be   = 4'(take_bits(4));
      if (be == '0) begin
        be = 4'hf;
      end
      issue(1'(take_bits(1)), make_addr(rnd_tag[pick], rnd_idx[pick], 4'(take_bits(4))),
            be, take_bits(32));
    end
    end_test();

    $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
             total_errors);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+bench
logic/cache_geom_pkg.sv
logic/cache_bus_pkg.sv
logic/tag_array.sv
logic/line_store.sv
logic/rw_ctrl.sv
logic/cache_rw_top.sv
bench/cache_rw_tb.sv

// File: Makefile
# verilator build and run of the cache read/write front end testbench

SRCS := $(wildcard logic/*.sv bench/*.sv bench/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vcache_rw_tb: flist.f $(SRCS)
	verilator --binary -j 0 --top-module cache_rw_tb -f flist.f -o Vcache_rw_tb

run: obj_dir/Vcache_rw_tb
	@out="$$(./obj_dir/Vcache_rw_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
